/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and address width
`define WORD_W 32

// Architectural register count
`define NUM_REGS 32

// First instruction address after reset
`define RESET_PC 32'h0000_0000

// Byte stride between consecutive words
`define WORD_BYTES 32'd4

`endif

/* isa_pkg.sv */
`include "cpu_macros.svh"

package isa_pkg;

	// Machine word and raw instruction word
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`WORD_W-1:0] instr_t;

	// Index into the register file
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	// Opcode field, bits 31:26
	typedef enum logic [5:0]
	{
		OP_HALT  = 6'b000000,
		// Jumps
		OP_J     = 6'b000100,
		OP_JR    = 6'b000101,
		OP_JAL   = 6'b000110,
		OP_JALR  = 6'b000111,
		// Immediate arithmetic and logic
		OP_ADDI  = 6'b001000,
		OP_SUBI  = 6'b001001,
		OP_XORI  = 6'b001010,
		OP_ANDNI = 6'b001011,
		// Branches against zero
		OP_BEQZ  = 6'b001100,
		OP_BNEZ  = 6'b001101,
		OP_BLTZ  = 6'b001110,
		OP_BGEZ  = 6'b001111,
		// Memory
		OP_ST    = 6'b010000,
		OP_LD    = 6'b010001,
		OP_SLBI  = 6'b010010,
		OP_STU   = 6'b010011,
		// Shifts and rotates
		OP_ROLI  = 6'b010100,
		OP_SLLI  = 6'b010101,
		OP_RORI  = 6'b010110,
		OP_SRLI  = 6'b010111,
		OP_LBI   = 6'b011000
	} opcode_e;

endpackage

/* bus_pkg.sv */
`include "cpu_macros.svh"

package bus_pkg;

	// Byte address on the memory bus, words aligned to 4
	typedef logic [`WORD_W-1:0] addr_t;

	// APB transfer phase
	typedef enum logic [1:0]
	{
		IDLE,
		SETUP,
		ACCESS
	} apb_phase_e;

	// Current bus owner
	typedef enum logic [1:0]
	{
		REQ_NONE,
		REQ_FETCH,
		REQ_DATA
	} requester_e;

endpackage

/* imm_decode.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module imm_decode
(
	input  isa_pkg::instr_t instr,
	output isa_pkg::word_t  imm
);

	import isa_pkg::*;

	opcode_e     op;
	logic [15:0] imm16;
	logic [25:0] imm26;

	assign op    = opcode_e'(instr[31:26]);
	assign imm16 = instr[15:0];
	assign imm26 = instr[25:0];

	always_comb
	begin
		case (op)
			// Logic immediates taken as unsigned
			OP_XORI, OP_ANDNI, OP_SLBI:
			begin
				imm = {{(`WORD_W-16){1'b0}}, imm16};
			end

			// Long jump offset
			OP_J, OP_JAL:
			begin
				imm = {{(`WORD_W-26){imm26[25]}}, imm26};
			end

			// Arithmetic and shift amounts
			OP_ADDI, OP_SUBI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI:
			begin
				imm = {{(`WORD_W-16){imm16[15]}}, imm16};
			end

			// Memory displacement
			OP_ST, OP_LD, OP_STU:
			begin
				imm = {{(`WORD_W-16){imm16[15]}}, imm16};
			end

			// Branch offsets, LBI and register jumps
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_LBI, OP_JR, OP_JALR:
			begin
				imm = {{(`WORD_W-16){imm16[15]}}, imm16};
			end

			// HALT and unknown opcodes carry no immediate
			default:
			begin
				imm = '0;
			end
		endcase
	end

endmodule

/* fetch_unit.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module fetch_unit
(
	input  logic            clk,
	input  logic            reset,
	input  logic            take,
	input  logic            redirect,
	input  bus_pkg::addr_t  target,
	output logic            instr_valid,
	output isa_pkg::instr_t instr,
	output bus_pkg::addr_t  pc,
	input  logic            halt,
	output logic            req,
	input  logic            done,
	output bus_pkg::addr_t  addr,
	input  isa_pkg::word_t  rdata
);

	import isa_pkg::*;
	import bus_pkg::*;

	addr_t  fetch_pc;
	addr_t  req_addr;
	logic   req_q;
	logic   flush;
	logic   buf_valid;
	instr_t buf_instr;
	addr_t  buf_pc;
	logic   issue;

	// Prefetch when the buffer is free now or frees this cycle
	assign issue = !req_q && !redirect && !halt && (!buf_valid || take);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fetch_pc  <= `RESET_PC;
			req_q     <= 1'b0;
			flush     <= 1'b0;
			buf_valid <= 1'b0;
		end
		else
		begin
			if (issue)
				req_q <= 1'b1;
			else if (done)
				req_q <= 1'b0;

			if (redirect)
				fetch_pc <= target;
			else if (issue)
				fetch_pc <= fetch_pc + `WORD_BYTES;

			// In-flight word on redirect is dropped when its done arrives
			if (redirect)
			begin
				buf_valid <= 1'b0;
				flush     <= req_q && !done;
			end
			else if (done && flush)
				flush <= 1'b0;
			else if (done)
				buf_valid <= 1'b1;
			else if (take)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			req_addr <= fetch_pc;
		if (done && !flush && !redirect)
		begin
			buf_instr <= rdata;
			buf_pc    <= req_addr;
		end
	end

	assign req         = req_q;
	assign addr        = req_addr;
	assign instr_valid = buf_valid;
	assign instr       = buf_instr;
	assign pc          = buf_pc;

endmodule

/* load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit
(
	input  logic           clk,
	input  logic           reset,
	input  logic           mem_start,
	input  logic           mem_write,
	input  bus_pkg::addr_t mem_addr,
	input  isa_pkg::word_t mem_wdata,
	output logic           mem_done,
	output isa_pkg::word_t mem_rdata,
	output logic           req,
	output logic           write,
	output bus_pkg::addr_t addr,
	output isa_pkg::word_t wdata,
	input  logic           done,
	input  isa_pkg::word_t rdata
);

	import isa_pkg::*;
	import bus_pkg::*;

	logic  req_q;
	logic  done_q;
	logic  write_q;
	addr_t addr_q;
	word_t wdata_q;
	word_t rdata_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_q  <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			if (mem_start)
				req_q <= 1'b1;
			else if (done)
				req_q <= 1'b0;
			done_q <= done;
		end
	end

	// Request payload held until the arbiter completes it
	always_ff @(posedge clk)
	begin
		if (mem_start)
		begin
			write_q <= mem_write;
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if (done && !write_q)
			rdata_q <= rdata;
	end

	assign req       = req_q;
	assign write     = write_q;
	assign addr      = addr_q;
	assign wdata     = wdata_q;
	assign mem_done  = done_q;
	assign mem_rdata = rdata_q;

endmodule

/* bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter
(
	input  logic           clk,
	input  logic           reset,
	input  logic           fetch_req,
	output logic           fetch_done,
	input  bus_pkg::addr_t fetch_addr,
	output isa_pkg::word_t fetch_rdata,
	input  logic           data_req,
	input  logic           data_write,
	input  bus_pkg::addr_t data_addr,
	input  isa_pkg::word_t data_wdata,
	output logic           data_done,
	output isa_pkg::word_t data_rdata,
	output bus_pkg::addr_t paddr,
	output logic           psel,
	output logic           penable,
	output logic           pwrite,
	output isa_pkg::word_t pwdata,
	input  isa_pkg::word_t prdata,
	input  logic           pready
);

	import bus_pkg::*;

	apb_phase_e phase;
	requester_e owner;
	logic       xfer_end;

	assign xfer_end = (phase == ACCESS) && pready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= IDLE;
			owner <= REQ_NONE;
		end
		else
		begin
			case (phase)
				IDLE:
				begin
					// Data side wins a tie
					if (data_req)
					begin
						owner <= REQ_DATA;
						phase <= SETUP;
					end
					else if (fetch_req)
					begin
						owner <= REQ_FETCH;
						phase <= SETUP;
					end
				end
				SETUP:
					phase <= ACCESS;
				ACCESS:
				begin
					if (pready)
					begin
						phase <= IDLE;
						owner <= REQ_NONE;
					end
				end
				default:
					phase <= IDLE;
			endcase
		end
	end

	assign psel    = (phase != IDLE);
	assign penable = (phase == ACCESS);

	// Owner payload onto the bus, stable while the owner is locked
	always_comb
	begin
		case (owner)
			REQ_DATA:
			begin
				paddr  = data_addr;
				pwrite = data_write;
				pwdata = data_wdata;
			end
			REQ_FETCH:
			begin
				paddr  = fetch_addr;
				pwrite = 1'b0;
				pwdata = '0;
			end
			default:
			begin
				paddr  = '0;
				pwrite = 1'b0;
				pwdata = '0;
			end
		endcase
	end

	assign fetch_done  = xfer_end && (owner == REQ_FETCH);
	assign data_done   = xfer_end && (owner == REQ_DATA);
	assign fetch_rdata = prdata;
	assign data_rdata  = prdata;

endmodule

/* exec_core.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module exec_core
(
	input  logic            clk,
	input  logic            reset,
	input  logic            instr_valid,
	input  isa_pkg::instr_t instr,
	input  bus_pkg::addr_t  pc,
	output logic            take,
	output logic            redirect,
	output bus_pkg::addr_t  target,
	output logic            halt,
	output logic            mem_start,
	output logic            mem_write,
	output bus_pkg::addr_t  mem_addr,
	output isa_pkg::word_t  mem_wdata,
	input  logic            mem_done,
	input  isa_pkg::word_t  mem_rdata,
	output logic            halted
);

	import isa_pkg::*;
	import bus_pkg::*;

	typedef enum logic [2:0]
	{
		S_DECODE,
		S_EXECUTE,
		S_MEM_WAIT,
		S_WRITEBACK,
		S_HALTED
	} core_state_e;

	core_state_e           state;
	word_t                 regs [`NUM_REGS];
	instr_t                instr_q;
	addr_t                 pc_q;
	addr_t                 pc_next;
	opcode_e               op;
	reg_idx_t              rs_idx;
	reg_idx_t              rd_idx;
	word_t                 rs_val;
	word_t                 rd_val;
	word_t                 imm;
	logic [4:0]            shamt;
	logic [2*`WORD_W-1:0]  rot_l;
	logic [2*`WORD_W-1:0]  rot_r;
	word_t                 alu_out;
	logic                  alu_we;
	reg_idx_t              alu_dst;
	logic                  is_mem;
	logic                  branch_taken;
	logic                  halt_now;
	logic                  wb_en;
	logic                  wb_load;
	reg_idx_t              wb_idx;
	word_t                 wb_data;

	imm_decode u_imm_decode
	(
		.instr (instr_q),
		.imm   (imm)
	);

	assign op      = opcode_e'(instr_q[31:26]);
	assign rs_idx  = instr_q[25:21];
	assign rd_idx  = instr_q[20:16];
	assign pc_next = pc_q + `WORD_BYTES;

	// r0 is hardwired to zero
	assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
	assign rd_val = (rd_idx == '0) ? '0 : regs[rd_idx];

	assign shamt = imm[4:0];
	assign rot_l = {rs_val, rs_val} << shamt;
	assign rot_r = {rs_val, rs_val} >> shamt;

	// Result and destination per opcode
	always_comb
	begin
		alu_out = '0;
		alu_we  = 1'b1;
		alu_dst = rd_idx;
		case (op)
			OP_ADDI:  alu_out = rs_val + imm;
			OP_SUBI:  alu_out = imm - rs_val;
			OP_XORI:  alu_out = rs_val ^ imm;
			OP_ANDNI: alu_out = rs_val & ~imm;
			OP_ROLI:  alu_out = rot_l[2*`WORD_W-1:`WORD_W];
			OP_SLLI:  alu_out = rs_val << shamt;
			OP_RORI:  alu_out = rot_r[`WORD_W-1:0];
			OP_SRLI:  alu_out = rs_val >> shamt;
			OP_LBI:   alu_out = imm;
			OP_SLBI:  alu_out = (rd_val << 16) | imm;
			// Load data comes back through the load/store unit
			OP_LD:    alu_out = '0;
			OP_STU:
			begin
				alu_out = mem_addr;
				alu_dst = rs_idx;
			end
			OP_JAL, OP_JALR:
			begin
				alu_out = pc_next;
				alu_dst = reg_idx_t'(`NUM_REGS - 1);
			end
			default:  alu_we = 1'b0;
		endcase
	end

	// Branch and jump resolution
	always_comb
	begin
		branch_taken = 1'b0;
		target       = pc_next + imm;
		case (op)
			OP_BEQZ: branch_taken = (rs_val == '0);
			OP_BNEZ: branch_taken = (rs_val != '0);
			OP_BLTZ: branch_taken = rs_val[`WORD_W-1];
			OP_BGEZ: branch_taken = !rs_val[`WORD_W-1];
			OP_J, OP_JAL: branch_taken = 1'b1;
			OP_JR, OP_JALR:
			begin
				branch_taken = 1'b1;
				target       = rs_val + imm;
			end
			default: branch_taken = 1'b0;
		endcase
	end

	assign is_mem    = (op == OP_ST) || (op == OP_LD) || (op == OP_STU);
	assign mem_write = (op == OP_ST) || (op == OP_STU);
	assign mem_addr  = rs_val + imm;
	assign mem_wdata = rd_val;
	assign mem_start = (state == S_EXECUTE) && is_mem;
	assign redirect  = (state == S_EXECUTE) && branch_taken;

	assign take     = (state == S_DECODE) && instr_valid;
	assign halt_now = take && (opcode_e'(instr[31:26]) == OP_HALT);
	// Stops the fetch unit from the cycle HALT is taken
	assign halt     = halted || halt_now;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= S_DECODE;
			halted <= 1'b0;
			wb_en  <= 1'b0;
		end
		else
		begin
			case (state)
				S_DECODE:
				begin
					if (halt_now)
					begin
						state  <= S_HALTED;
						halted <= 1'b1;
					end
					else if (take)
						state <= S_EXECUTE;
				end
				S_EXECUTE:
				begin
					wb_en <= alu_we;
					state <= is_mem ? S_MEM_WAIT : S_WRITEBACK;
				end
				S_MEM_WAIT:
				begin
					if (mem_done)
						state <= S_WRITEBACK;
				end
				S_WRITEBACK:
					state <= S_DECODE;
				S_HALTED:
					state <= S_HALTED;
				default:
					state <= S_DECODE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			instr_q <= instr;
			pc_q    <= pc;
		end
		if (state == S_EXECUTE)
		begin
			wb_idx  <= alu_dst;
			wb_data <= alu_out;
			wb_load <= (op == OP_LD);
		end
		if ((state == S_WRITEBACK) && wb_en && (wb_idx != '0))
			regs[wb_idx] <= wb_load ? mem_rdata : wb_data;
	end

endmodule

/* wisc_top.sv */
`timescale 1ns/100ps

module wisc_top
(
	input  logic           clk,
	input  logic           reset,
	output bus_pkg::addr_t paddr,
	output logic           psel,
	output logic           penable,
	output logic           pwrite,
	output isa_pkg::word_t pwdata,
	input  isa_pkg::word_t prdata,
	input  logic           pready,
	output logic           halted
);

	import isa_pkg::*;
	import bus_pkg::*;

	// Core to fetch unit
	logic   instr_valid;
	instr_t instr;
	addr_t  pc;
	logic   take;
	logic   redirect;
	addr_t  target;
	logic   halt;

	// Core to load/store unit
	logic   mem_start;
	logic   mem_write;
	addr_t  mem_addr;
	word_t  mem_wdata;
	logic   mem_done;
	word_t  mem_rdata;

	// Peers to arbiter
	logic   fetch_req;
	logic   fetch_done;
	addr_t  fetch_addr;
	word_t  fetch_rdata;
	logic   data_req;
	logic   data_write;
	addr_t  data_addr;
	word_t  data_wdata;
	logic   data_done;
	word_t  data_rdata;

	fetch_unit u_fetch
	(
		.clk         (clk),
		.reset       (reset),
		.take        (take),
		.redirect    (redirect),
		.target      (target),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.halt        (halt),
		.req         (fetch_req),
		.done        (fetch_done),
		.addr        (fetch_addr),
		.rdata       (fetch_rdata)
	);

	load_store_unit u_lsu
	(
		.clk       (clk),
		.reset     (reset),
		.mem_start (mem_start),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_done  (mem_done),
		.mem_rdata (mem_rdata),
		.req       (data_req),
		.write     (data_write),
		.addr      (data_addr),
		.wdata     (data_wdata),
		.done      (data_done),
		.rdata     (data_rdata)
	);

	bus_arbiter u_arbiter
	(
		.clk         (clk),
		.reset       (reset),
		.fetch_req   (fetch_req),
		.fetch_done  (fetch_done),
		.fetch_addr  (fetch_addr),
		.fetch_rdata (fetch_rdata),
		.data_req    (data_req),
		.data_write  (data_write),
		.data_addr   (data_addr),
		.data_wdata  (data_wdata),
		.data_done   (data_done),
		.data_rdata  (data_rdata),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready)
	);

	exec_core u_core
	(
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.take        (take),
		.redirect    (redirect),
		.target      (target),
		.halt        (halt),
		.mem_start   (mem_start),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_done    (mem_done),
		.mem_rdata   (mem_rdata),
		.halted      (halted)
	);

endmodule

/* wisc_top_assert.sv */
`timescale 1ns/100ps

module wisc_top_assert
(
	input logic           clk,
	input logic           reset,
	input bus_pkg::addr_t paddr,
	input logic           psel,
	input logic           penable,
	input isa_pkg::word_t pwdata,
	input logic           pready,
	input logic           halted,
	input logic           fetch_req,
	input logic           data_req
);

	// SETUP cycle precedes ACCESS
	a_setup_first: assert property (@(posedge clk) disable iff (reset)
		$rose(penable) |-> $past(psel))
		else $error("penable rose without psel in the previous cycle");

	a_payload_stable: assert property (@(posedge clk) disable iff (reset)
		penable |-> $stable(paddr) && $stable(pwdata))
		else $error("paddr or pwdata changed during ACCESS");

	a_wait_holds: assert property (@(posedge clk) disable iff (reset)
		penable && !pready |=> penable)
		else $error("penable dropped before pready");

	a_access_ends: assert property (@(posedge clk) disable iff (reset)
		penable && pready |=> !penable)
		else $error("penable stayed high after pready");

	// Nothing moves on the bus once the core has stopped
	a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
		halted |-> !psel && !fetch_req && !data_req)
		else $error("bus activity after halted");

	a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else $error("halted fell before reset");

endmodule

bind wisc_top wisc_top_assert u_assert
(
	.clk       (clk),
	.reset     (reset),
	.paddr     (paddr),
	.psel      (psel),
	.penable   (penable),
	.pwdata    (pwdata),
	.pready    (pready),
	.halted    (halted),
	.fetch_req (fetch_req),
	.data_req  (data_req)
);

/* wisc_top_tb.sv */
`timescale 1ns/100ps

module wisc_top_tb;

	import isa_pkg::*;
	import bus_pkg::*;

	localparam word_t RES_BASE = 32'h0000_0200;
	localparam int    HALT_LIMIT = 20000;

	logic  clk;
	logic  reset;
	addr_t paddr;
	logic  psel;
	logic  penable;
	logic  pwrite;
	word_t pwdata;
	word_t prdata;
	logic  pready;
	logic  halted;

	// 1 KB of word memory, code from 0, results from RES_BASE
	word_t      mem [256];
	logic [7:0] pc_w;
	logic [7:0] slot;
	logic [7:0] chk_idx [$];
	word_t      chk_val [$];
	word_t      rng;
	logic [1:0] wait_left;

	wisc_top UUT
	(
		.clk     (clk),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.halted  (halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t fill_value(input logic [7:0] idx);
		return ({24'b0, idx} * 32'h9E37_79B9) ^ 32'hC3A5_5A3C;
	endfunction

	function automatic word_t sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t zext16(input logic [15:0] v);
		return {16'h0000, v};
	endfunction

	function automatic word_t rotate_left(input word_t x, input logic [4:0] n);
		word_t r;
		r = x;
		for (int k = 0; k < int'(n); k++)
			r = {r[30:0], r[31]};
		return r;
	endfunction

	function automatic word_t rotate_right(input word_t x, input logic [4:0] n);
		word_t r;
		r = x;
		for (int k = 0; k < int'(n); k++)
			r = {r[0], r[31:1]};
		return r;
	endfunction

	function automatic logic branch_expected(input opcode_e op, input word_t v);
		case (op)
			OP_BEQZ: return v == 32'd0;
			OP_BNEZ: return v != 32'd0;
			OP_BLTZ: return v[31];
			default: return !v[31];
		endcase
	endfunction

	function automatic instr_t enc_i(input opcode_e op, input reg_idx_t rs, input reg_idx_t rd,
		input logic [15:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic instr_t enc_j(input opcode_e op, input logic [25:0] off);
		return {op, off};
	endfunction

	task automatic emit(input instr_t w);
		mem[pc_w] = w;
		pc_w = pc_w + 8'd1;
	endtask

	// Record the word expected in the next result slot
	task automatic expect_slot(input word_t value);
		chk_idx.push_back(8'd128 + slot);
		chk_val.push_back(value);
		slot = slot + 8'd1;
	endtask

	task automatic store_result(input reg_idx_t src, input word_t value);
		emit(enc_i(OP_ST, 5'd1, src, 16'({slot, 2'b00})));
		expect_slot(value);
	endtask

	// A store that control flow must jump over, so the slot keeps its fill
	task automatic skipped_store();
		emit(enc_i(OP_ST, 5'd1, 5'd21, 16'({slot, 2'b00})));
		expect_slot(fill_value(8'd128 + slot));
	endtask

	task automatic imm_op(input opcode_e op, input reg_idx_t rs, input reg_idx_t rd,
		input logic [15:0] imm, input word_t expected);
		emit(enc_i(op, rs, rd, imm));
		store_result(rd, expected);
	endtask

	task automatic shift_set(input word_t v, input logic [15:0] imm);
		imm_op(OP_SLLI, 5'd11, 5'd12, imm, v << imm[4:0]);
		imm_op(OP_SRLI, 5'd11, 5'd13, imm, v >> imm[4:0]);
		imm_op(OP_ROLI, 5'd11, 5'd14, imm, rotate_left(v, imm[4:0]));
		imm_op(OP_RORI, 5'd11, 5'd15, imm, rotate_right(v, imm[4:0]));
	endtask

	// Branch over one store, taken or not by the branch rule
	task automatic branch_case(input opcode_e op, input reg_idx_t rs, input word_t v);
		emit(enc_i(op, rs, 5'd0, 16'h0004));
		if (branch_expected(op, v))
			skipped_store();
		else
			store_result(5'd21, 32'h0000_0BAD);
	endtask

	task automatic load_program();
		word_t      v_five;
		word_t      v_ones;
		word_t      v_const;
		word_t      a;
		word_t      t;
		logic [7:0] s_const;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_value(i[7:0]);
		pc_w = 8'd0;
		slot = 8'd0;
		v_five = sext16(16'h0005);
		v_ones = sext16(16'hFFFF);
		emit(enc_i(OP_LBI, 5'd0, 5'd1, 16'h0200));
		emit(enc_i(OP_LBI, 5'd0, 5'd2, 16'h0005));
		emit(enc_i(OP_LBI, 5'd0, 5'd7, 16'hFFFF));
		emit(enc_i(OP_LBI, 5'd0, 5'd21, 16'h0BAD));
		// Sign versus zero extension shows in the upper half
		imm_op(OP_ADDI, 5'd2, 5'd3, 16'hFFFD, v_five + sext16(16'hFFFD));
		imm_op(OP_SUBI, 5'd2, 5'd4, 16'hFFF0, sext16(16'hFFF0) - v_five);
		imm_op(OP_XORI, 5'd2, 5'd5, 16'h8001, v_five ^ zext16(16'h8001));
		imm_op(OP_ANDNI, 5'd7, 5'd6, 16'h00F0, v_ones & ~zext16(16'h00F0));
		imm_op(OP_ANDNI, 5'd7, 5'd8, 16'h8000, v_ones & ~zext16(16'h8000));
		imm_op(OP_ADDI, 5'd0, 5'd9, 16'h8000, 32'd0 + sext16(16'h8000));
		imm_op(OP_XORI, 5'd7, 5'd10, 16'hFFFF, v_ones ^ zext16(16'hFFFF));
		// Full 32-bit constant, then shifts and rotates of it
		imm_op(OP_LBI, 5'd0, 5'd11, 16'h8765, sext16(16'h8765));
		v_const = (sext16(16'h8765) << 16) | zext16(16'h4321);
		s_const = slot;
		imm_op(OP_SLBI, 5'd0, 5'd11, 16'h4321, v_const);
		shift_set(v_const, 16'h0000);
		shift_set(v_const, 16'h0004);
		shift_set(v_const, 16'h002D);
		shift_set(v_const, 16'hFFFF);
		// Load back, then STU and a negative displacement
		emit(enc_i(OP_LD, 5'd1, 5'd17, 16'({s_const, 2'b00})));
		store_result(5'd17, v_const);
		emit(enc_i(OP_ADDI, 5'd1, 5'd18, 16'h0000));
		a = RES_BASE + word_t'({slot, 2'b00});
		emit(enc_i(OP_STU, 5'd18, 5'd2, 16'({slot, 2'b00})));
		expect_slot(v_five);
		emit(enc_i(OP_LD, 5'd18, 5'd20, 16'hFFFC));
		store_result(5'd20, v_const);
		store_result(5'd18, a);
		branch_case(OP_BEQZ, 5'd0, 32'd0);
		branch_case(OP_BEQZ, 5'd2, v_five);
		branch_case(OP_BNEZ, 5'd2, v_five);
		branch_case(OP_BNEZ, 5'd0, 32'd0);
		branch_case(OP_BLTZ, 5'd7, v_ones);
		branch_case(OP_BLTZ, 5'd2, v_five);
		branch_case(OP_BGEZ, 5'd0, 32'd0);
		branch_case(OP_BGEZ, 5'd7, v_ones);
		emit(enc_j(OP_J, 26'd4));
		skipped_store();
		a = word_t'({pc_w, 2'b00});
		emit(enc_j(OP_JAL, 26'd4));
		skipped_store();
		store_result(5'd31, a + 32'd4);
		t = word_t'({pc_w, 2'b00}) + 32'd12;
		emit(enc_i(OP_LBI, 5'd0, 5'd22, 16'(t + 32'd8)));
		emit(enc_i(OP_JR, 5'd22, 5'd0, 16'hFFF8));
		skipped_store();
		t = word_t'({pc_w, 2'b00}) + 32'd12;
		emit(enc_i(OP_LBI, 5'd0, 5'd23, 16'(t)));
		a = word_t'({pc_w, 2'b00});
		emit(enc_i(OP_JALR, 5'd23, 5'd0, 16'h0000));
		skipped_store();
		store_result(5'd31, a + 32'd4);
		emit(32'h0000_0000);
	endtask

	// APB slave with 0 to 3 wait states per transfer
	initial
	begin
		load_program();
		rng = 32'd39954;
		wait_left = 2'd0;
		pready = 1'b0;
		prdata = '0;
		forever
		begin
			@(negedge clk);
			pready = 1'b0;
			if (psel && !penable)
			begin
				wait_left = rng[1:0];
				rng = xorshift(rng);
			end
			else if (psel && penable)
			begin
				if (wait_left == 2'd0)
				begin
					pready = 1'b1;
					if (pwrite)
						mem[paddr[9:2]] = pwdata;
					else
						prdata = mem[paddr[9:2]];
				end
				else
					wait_left = wait_left - 2'd1;
			end
		end
	end

	task automatic stop_with_failure();
		$display("tests failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input logic [7:0] idx, input word_t expected);
		word_t got;
		got = mem[idx];
		assert (got === expected)
		else
		begin
			$display("Mismatch at %0t: mem[0x%03h] got 0x%08h expected 0x%08h",
				$time, {idx, 2'b00}, got, expected);
			stop_with_failure();
		end
	endtask

	initial
	begin
		int cycles;
		reset = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		assert (!psel && !penable && !halted)
		else
		begin
			$display("Bus or halted not idle after reset");
			stop_with_failure();
		end
		cycles = 0;
		while (!halted && cycles < HALT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
		begin
			$display("Timeout: halted did not rise within %0d cycles", HALT_LIMIT);
			stop_with_failure();
		end
		// Quiet period watched by the bound bus checks
		repeat (20) @(negedge clk);
		assert (halted)
		else
		begin
			$display("halted dropped after HALT was taken");
			stop_with_failure();
		end
		for (int i = 0; i < chk_val.size(); i++)
			check_word(chk_idx[i], chk_val[i]);
		$display("all tests passed");
		$finish;
	end

endmodule

/* wisc_top.f */
+incdir+.
isa_pkg.sv
bus_pkg.sv
imm_decode.sv
fetch_unit.sv
load_store_unit.sv
bus_arbiter.sv
exec_core.sv
wisc_top.sv
wisc_top_assert.sv
wisc_top_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; any failure stops the script
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f wisc_top.f \
	--top-module wisc_top_tb \
	-o wisc_top_sim

./obj_dir/wisc_top_sim
